// File: source/lc3b_config.svh
`ifndef LC3B_CONFIG_SVH
`define LC3B_CONFIG_SVH

// Memory line geometry, shared by fetch and data ports
`define LC3B_LINE_BITS 128
`define LC3B_OFFSET_BITS 4

`define LC3B_NUM_REGS 8

// Instructions fetched behind a branch by the time it reaches memory stage
`define LC3B_BRANCH_SHADOW 3

`endif

// File: source/lc3b_types.sv
`default_nettype none
`include "lc3b_config.svh"

package lc3b_types;

	typedef logic [15:0] lc3b_word;
	typedef logic [$clog2(`LC3B_NUM_REGS)-1:0] lc3b_reg;
	typedef logic [2:0] lc3b_nzp;
	typedef logic [`LC3B_LINE_BITS-1:0] lc3b_line;
	typedef logic [15-`LC3B_OFFSET_BITS:0] lc3b_wb_adr;
	typedef logic [`LC3B_LINE_BITS/8-1:0] lc3b_sel;

	typedef enum logic [3:0] {
		op_br  = 4'b0000,
		op_add = 4'b0001,
		op_and = 4'b0101,
		op_ldr = 4'b0110,
		op_str = 4'b0111,
		op_not = 4'b1001
	} lc3b_opcode;

	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_reg dr;
		lc3b_reg sr1;
		logic imm_flag;
		logic [1:0] unused;
		lc3b_reg sr2;
	} lc3b_instr_reg;

	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_reg dr;
		lc3b_reg sr1;
		logic imm_flag;
		logic [4:0] imm5;
	} lc3b_instr_imm;

	// LDR uses dr_sr as destination, STR as store source
	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_reg dr_sr;
		lc3b_reg base;
		logic [5:0] offset6;
	} lc3b_instr_mem;

	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_nzp nzp;
		logic [8:0] offset9;
	} lc3b_instr_br;

	typedef union packed {
		lc3b_instr_reg r;
		lc3b_instr_imm i;
		lc3b_instr_mem m;
		lc3b_instr_br b;
	} lc3b_instr;

endpackage : lc3b_types

`default_nettype wire

// File: source/lc3b_ctrl_types.sv
`default_nettype none

package lc3b_ctrl_types;

	typedef enum logic [1:0] {alu_add, alu_and, alu_not, alu_pass} lc3b_aluop;

	typedef enum logic [1:0] {alumux_reg, alumux_off6, alumux_zero} lc3b_alumux_sel;

	typedef enum logic {sr2mux_reg, sr2mux_imm} lc3b_sr2mux_sel;

	typedef enum logic {wbmux_alu, wbmux_mem} lc3b_wbmux_sel;

	typedef enum logic {mem_idle, mem_access} lc3b_mem_state;

	typedef struct packed {
		lc3b_aluop aluop;
		lc3b_alumux_sel alumux_sel;
		lc3b_sr2mux_sel sr2mux_sel;
		lc3b_wbmux_sel wbmux_sel;
		logic load_cc;
		logic load_regfile;
		logic mem_read;
		logic mem_write;
		logic is_br;
	} lc3b_control_word;

endpackage : lc3b_ctrl_types

`default_nettype wire

// File: source/control_rom.sv
`default_nettype none
`timescale 1ns/1ps

module control_rom (
	input lc3b_types::lc3b_opcode opcode,
	input logic imm_mode,
	output lc3b_ctrl_types::lc3b_control_word ctrl
);
	import lc3b_types::*;
	import lc3b_ctrl_types::*;

	always_comb begin
		// Anything not listed below behaves as a NOP
		ctrl = '0;
		ctrl.aluop = alu_pass;
		ctrl.alumux_sel = alumux_zero;
		ctrl.sr2mux_sel = sr2mux_reg;
		ctrl.wbmux_sel = wbmux_alu;

		case (opcode)
			op_add, op_and: begin
				ctrl.aluop = (opcode == op_add) ? alu_add : alu_and;
				ctrl.alumux_sel = alumux_reg;
				ctrl.sr2mux_sel = imm_mode ? sr2mux_imm : sr2mux_reg;
				ctrl.load_cc = 1'b1;
				ctrl.load_regfile = 1'b1;
			end
			op_not: begin
				ctrl.aluop = alu_not;
				ctrl.alumux_sel = alumux_reg;
				ctrl.load_cc = 1'b1;
				ctrl.load_regfile = 1'b1;
			end
			op_ldr: begin
				ctrl.aluop = alu_add;
				ctrl.alumux_sel = alumux_off6;
				ctrl.wbmux_sel = wbmux_mem;
				ctrl.load_cc = 1'b1;
				ctrl.load_regfile = 1'b1;
				ctrl.mem_read = 1'b1;
			end
			op_str: begin
				ctrl.aluop = alu_add;
				ctrl.alumux_sel = alumux_off6;
				ctrl.mem_write = 1'b1;
			end
			op_br: begin
				ctrl.is_br = 1'b1;
			end
			default: begin
			end
		endcase
	end

endmodule : control_rom

`default_nettype wire

// File: source/regfile.sv
`default_nettype none
`timescale 1ns/1ps
`include "lc3b_config.svh"

module regfile (
	input logic clk,
	input logic reset,
	input logic load,
	input lc3b_types::lc3b_reg dest,
	input lc3b_types::lc3b_word in,
	input lc3b_types::lc3b_reg src_a,
	input lc3b_types::lc3b_reg src_b,
	input lc3b_types::lc3b_reg sr,
	output lc3b_types::lc3b_word reg_a,
	output lc3b_types::lc3b_word reg_b,
	output lc3b_types::lc3b_word sr_out
);
	import lc3b_types::*;

	lc3b_word data [`LC3B_NUM_REGS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `LC3B_NUM_REGS; i++) begin
				data[i] <= '0;
			end
		end else if (load) begin
			data[dest] <= in;
		end
	end

	// Write-through so decode sees a value retiring in the same cycle
	assign reg_a = (load && dest == src_a) ? in : data[src_a];
	assign reg_b = (load && dest == src_b) ? in : data[src_b];
	assign sr_out = (load && dest == sr) ? in : data[sr];

endmodule : regfile

`default_nettype wire

// File: source/alu.sv
`default_nettype none
`timescale 1ns/1ps

module alu (
	input lc3b_ctrl_types::lc3b_aluop aluop,
	input lc3b_types::lc3b_word a,
	input lc3b_types::lc3b_word b,
	output lc3b_types::lc3b_word f,
	output lc3b_types::lc3b_nzp nzp
);
	import lc3b_ctrl_types::*;

	always_comb begin
		unique case (aluop)
			alu_add: f = a + b;
			alu_and: f = a & b;
			alu_not: f = ~a;
			alu_pass: f = b;
		endcase
	end

	// n, z, p from the result sign
	assign nzp[2] = f[15];
	assign nzp[1] = (f == '0);
	assign nzp[0] = !f[15] && (f != '0);

endmodule : alu

`default_nettype wire

// File: source/mem_stall_fsm.sv
`default_nettype none
`timescale 1ns/1ps

module mem_stall_fsm (
	input logic clk,
	input logic reset,
	input logic mem_read_req,
	input logic mem_write_req,
	input logic mem_resp,
	output logic mem_read,
	output logic mem_write,
	output logic stall
);
	import lc3b_ctrl_types::*;

	lc3b_mem_state state;
	logic req;

	assign req = mem_read_req | mem_write_req;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= mem_idle;
		end else begin
			case (state)
				mem_idle: if (req) state <= mem_access;
				mem_access: if (mem_resp) state <= mem_idle;
				default: state <= mem_idle;
			endcase
		end
	end

	assign mem_read = (state == mem_access) && mem_read_req;
	assign mem_write = (state == mem_access) && mem_write_req;

	// Pipeline advances only in the cycle the response arrives
	assign stall = (state == mem_idle) ? req : !mem_resp;

	one_request_kind: assert property (@(posedge clk) disable iff (reset)
		!(mem_read && mem_write));

	access_needs_request: assert property (@(posedge clk) disable iff (reset)
		(state == mem_access) |-> req);

endmodule : mem_stall_fsm

`default_nettype wire

// File: source/branch_shadow_timer.sv
`default_nettype none
`timescale 1ns/1ps
`include "lc3b_config.svh"

module branch_shadow_timer (
	input logic clk,
	input logic reset,
	input logic branch_taken,
	input logic stall,
	output logic squash
);
	localparam int count_bits = $clog2(`LC3B_BRANCH_SHADOW + 1);

	logic [count_bits-1:0] count;

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else if (branch_taken) begin
			count <= count_bits'(`LC3B_BRANCH_SHADOW);
		end else if (!stall && count != '0) begin
			count <= count - 1'b1;
		end
	end

	assign squash = (count != '0);

	// Datapath gates branches with squash, so no nested redirect
	no_branch_in_shadow: assert property (@(posedge clk) disable iff (reset)
		!(branch_taken && squash));

endmodule : branch_shadow_timer

`default_nettype wire

// File: source/datapath.sv
`default_nettype none
`timescale 1ns/1ps
`include "lc3b_config.svh"

module datapath (
	input logic clk,
	input logic reset,
	input logic stall,
	input logic squash,
	input lc3b_types::lc3b_line ifetch_rdata,
	output lc3b_types::lc3b_wb_adr ifetch_address,
	input lc3b_types::lc3b_line mem_rdata,
	output lc3b_types::lc3b_wb_adr mem_address,
	output lc3b_types::lc3b_line mem_wdata,
	output lc3b_types::lc3b_sel mem_sel,
	output logic mem_read_req,
	output logic mem_write_req,
	output logic branch_taken,
	output lc3b_types::lc3b_opcode opcode,
	output logic imm_mode,
	input lc3b_ctrl_types::lc3b_control_word ctrl_in
);
	import lc3b_types::*;
	import lc3b_ctrl_types::*;

	function automatic lc3b_word line_word(input lc3b_line line,
			input logic [`LC3B_OFFSET_BITS-2:0] idx);
		return line[idx * 16 +: 16];
	endfunction

	lc3b_word pc;
	lc3b_word pc_plus2;
	lc3b_word fetch_word;

	lc3b_instr if_id_instr;
	lc3b_word if_id_pc;
	logic if_id_valid;

	lc3b_word reg_a;
	lc3b_word reg_b;
	lc3b_word store_data;
	lc3b_word sext5;
	lc3b_word off6;
	lc3b_word off9;

	lc3b_control_word id_ex_ctrl;
	lc3b_word id_ex_sr1;
	lc3b_word id_ex_sr2;
	lc3b_word id_ex_off6;
	lc3b_word id_ex_off9;
	lc3b_word id_ex_pc;
	lc3b_word id_ex_sdata;
	lc3b_reg id_ex_dest;
	lc3b_nzp id_ex_nzp;
	logic id_ex_valid;

	lc3b_word alu_b;
	lc3b_word alu_out;
	lc3b_word target;

	lc3b_control_word ex_mem_ctrl;
	lc3b_word ex_mem_alu;
	lc3b_word ex_mem_target;
	lc3b_word ex_mem_sdata;
	lc3b_reg ex_mem_dest;
	lc3b_nzp ex_mem_nzp;
	logic ex_mem_valid;
	logic ex_mem_live;

	logic [`LC3B_OFFSET_BITS-2:0] mem_idx;
	lc3b_word wbmux_out;
	lc3b_word wb_word;
	lc3b_nzp wb_nzp;
	lc3b_nzp cc;

	lc3b_word mem_wb_data;
	lc3b_reg mem_wb_dest;
	logic mem_wb_load;
	logic mem_wb_valid;

	// Fetch
	assign pc_plus2 = pc + 16'd2;
	assign ifetch_address = pc[15:`LC3B_OFFSET_BITS];
	assign fetch_word = line_word(ifetch_rdata, pc[`LC3B_OFFSET_BITS-1:1]);

	// Decode
	assign opcode = if_id_instr.r.opcode;
	assign imm_mode = if_id_instr.i.imm_flag;
	assign sext5 = {{11{if_id_instr.i.imm5[4]}}, if_id_instr.i.imm5};
	assign off6 = {{9{if_id_instr.m.offset6[5]}}, if_id_instr.m.offset6, 1'b0};
	assign off9 = {{6{if_id_instr.b.offset9[8]}}, if_id_instr.b.offset9, 1'b0};

	regfile regs (
		.clk,
		.reset,
		.load(mem_wb_valid && mem_wb_load && !stall),
		.dest(mem_wb_dest),
		.in(mem_wb_data),
		.src_a(if_id_instr.r.sr1),
		.src_b(if_id_instr.r.sr2),
		.sr(if_id_instr.m.dr_sr),
		.reg_a(reg_a),
		.reg_b(reg_b),
		.sr_out(store_data)
	);

	// Execute
	always_comb begin
		case (id_ex_ctrl.alumux_sel)
			alumux_reg: alu_b = id_ex_sr2;
			alumux_off6: alu_b = id_ex_off6;
			default: alu_b = '0;
		endcase
	end

	alu ex_alu (
		.aluop(id_ex_ctrl.aluop),
		.a(id_ex_sr1),
		.b(alu_b),
		.f(alu_out),
		.nzp()
	);

	assign target = id_ex_pc + id_ex_off9;

	// Memory stage; squash covers the wrong-path instructions behind a taken BR
	assign ex_mem_live = ex_mem_valid && !squash;
	assign mem_read_req = ex_mem_live && ex_mem_ctrl.mem_read;
	assign mem_write_req = ex_mem_live && ex_mem_ctrl.mem_write;

	assign mem_idx = ex_mem_alu[`LC3B_OFFSET_BITS-1:1];
	assign mem_address = ex_mem_alu[15:`LC3B_OFFSET_BITS];
	assign mem_wdata = lc3b_line'(ex_mem_sdata) << (mem_idx * 16);
	assign mem_sel = lc3b_sel'(2'b11) << (mem_idx * 2);

	assign wbmux_out = (ex_mem_ctrl.wbmux_sel == wbmux_mem) ?
		line_word(mem_rdata, mem_idx) : ex_mem_alu;

	// Flags of the word being retired, loads included
	alu wb_flags (
		.aluop(alu_pass),
		.a(ex_mem_alu),
		.b(wbmux_out),
		.f(wb_word),
		.nzp(wb_nzp)
	);

	assign branch_taken = ex_mem_live && ex_mem_ctrl.is_br && ((ex_mem_nzp & cc) != '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			if_id_valid <= 1'b0;
			id_ex_valid <= 1'b0;
			ex_mem_valid <= 1'b0;
			mem_wb_valid <= 1'b0;
			cc <= 3'b010;
		end else if (!stall) begin
			pc <= branch_taken ? ex_mem_target : pc_plus2;
			if_id_valid <= 1'b1;
			id_ex_valid <= if_id_valid;
			ex_mem_valid <= id_ex_valid;
			mem_wb_valid <= ex_mem_live;
			if (ex_mem_live && ex_mem_ctrl.load_cc) begin
				cc <= wb_nzp;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			if_id_instr <= fetch_word;
			if_id_pc <= pc_plus2;

			id_ex_ctrl <= ctrl_in;
			id_ex_sr1 <= reg_a;
			id_ex_sr2 <= (ctrl_in.sr2mux_sel == sr2mux_imm) ? sext5 : reg_b;
			id_ex_off6 <= off6;
			id_ex_off9 <= off9;
			id_ex_pc <= if_id_pc;
			id_ex_sdata <= store_data;
			id_ex_dest <= if_id_instr.r.dr;
			id_ex_nzp <= if_id_instr.b.nzp;

			ex_mem_ctrl <= id_ex_ctrl;
			ex_mem_alu <= alu_out;
			ex_mem_target <= target;
			ex_mem_sdata <= id_ex_sdata;
			ex_mem_dest <= id_ex_dest;
			ex_mem_nzp <= id_ex_nzp;

			mem_wb_data <= wb_word;
			mem_wb_dest <= ex_mem_dest;
			mem_wb_load <= ex_mem_ctrl.load_regfile;
		end
	end

	mem_stable_under_stall: assert property (@(posedge clk) disable iff (reset)
		stall |=> $stable(mem_address) && $stable(mem_wdata));

endmodule : datapath

`default_nettype wire

// File: source/cpu.sv
`default_nettype none
`timescale 1ns/1ps

module cpu (
	input logic clk,
	input logic reset,
	input lc3b_types::lc3b_line ifetch_rdata,
	output lc3b_types::lc3b_wb_adr ifetch_address,
	input lc3b_types::lc3b_line mem_rdata,
	input logic mem_resp,
	output logic mem_read,
	output logic mem_write,
	output lc3b_types::lc3b_line mem_wdata,
	output lc3b_types::lc3b_wb_adr mem_address,
	output lc3b_types::lc3b_sel mem_sel
);
	import lc3b_types::*;
	import lc3b_ctrl_types::*;

	logic stall;
	logic squash;
	logic branch_taken;
	logic mem_read_req;
	logic mem_write_req;
	logic imm_mode;
	lc3b_opcode opcode;
	lc3b_control_word ctrl;

	datapath dp (
		.clk,
		.reset,
		.stall,
		.squash,
		.ifetch_rdata,
		.ifetch_address,
		.mem_rdata,
		.mem_address,
		.mem_wdata,
		.mem_sel,
		.mem_read_req,
		.mem_write_req,
		.branch_taken,
		.opcode,
		.imm_mode,
		.ctrl_in(ctrl)
	);

	control_rom rom (
		.opcode,
		.imm_mode,
		.ctrl
	);

	mem_stall_fsm mem_fsm (
		.clk,
		.reset,
		.mem_read_req,
		.mem_write_req,
		.mem_resp,
		.mem_read,
		.mem_write,
		.stall
	);

	branch_shadow_timer shadow (
		.clk,
		.reset,
		.branch_taken,
		.stall,
		.squash
	);

endmodule : cpu

`default_nettype wire

// File: verification/cpu_tb.sv
`default_nettype none
`timescale 1ns/1ps
`include "lc3b_config.svh"

module cpu_tb;
	import lc3b_types::*;

	localparam int clk_period = 8;
	localparam int words_per_line = `LC3B_LINE_BITS / 16;
	localparam int imem_words = 64;
	localparam int dmem_words = 32;
	localparam int num_rows = 10;
	localparam int num_passes = 2;
	localparam int drain_cycles = 16;

	// Opcodes as listed in the ISA
	localparam logic [3:0] opc_br = 4'b0000;
	localparam logic [3:0] opc_add = 4'b0001;
	localparam logic [3:0] opc_and = 4'b0101;
	localparam logic [3:0] opc_ldr = 4'b0110;
	localparam logic [3:0] opc_str = 4'b0111;
	localparam logic [3:0] opc_not = 4'b1001;

	typedef struct packed {
		logic [3:0] op;
		logic imm;
		logic [2:0] cond;
		logic [2:0] offset;
	} test_row;

	// Operation, immediate flag, BR nzp, word offset of the result store
	test_row rows [num_rows] = '{
		'{opc_add, 1'b0, 3'b100, 3'd0},
		'{opc_add, 1'b1, 3'b001, 3'd1},
		'{opc_and, 1'b0, 3'b010, 3'd2},
		'{opc_and, 1'b1, 3'b111, 3'd3},
		'{opc_not, 1'b0, 3'b100, 3'd4},
		'{opc_not, 1'b0, 3'b001, 3'd5},
		'{opc_add, 1'b0, 3'b000, 3'd6},
		'{opc_and, 1'b1, 3'b011, 3'd7},
		'{opc_add, 1'b1, 3'b110, 3'd0},
		'{opc_not, 1'b0, 3'b101, 3'd6}
	};

	logic clk;
	logic reset;
	lc3b_line ifetch_rdata;
	lc3b_wb_adr ifetch_address;
	lc3b_line mem_rdata;
	logic mem_resp;
	logic mem_read;
	logic mem_write;
	lc3b_line mem_wdata;
	lc3b_wb_adr mem_address;
	lc3b_sel mem_sel;

	lc3b_word imem [imem_words];
	lc3b_word dmem [dmem_words];
	logic [31:0] lfsr_state = 32'h716a8fe6;
	logic random_delay = 1'b0;

	lc3b_word op_a [num_rows];
	lc3b_word op_b [num_rows];
	logic [4:0] op_imm [num_rows];

	lc3b_wb_adr seen_addr [$];
	lc3b_line seen_data [$];
	lc3b_sel seen_sel [$];
	int exp_word [$];
	lc3b_word exp_data [$];

	cpu DUT (
		.clk(clk),
		.reset(reset),
		.ifetch_rdata(ifetch_rdata),
		.ifetch_address(ifetch_address),
		.mem_rdata(mem_rdata),
		.mem_resp(mem_resp),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.mem_wdata(mem_wdata),
		.mem_address(mem_address),
		.mem_sel(mem_sel)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
	endfunction

	task automatic take_bits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			value[i] = lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic check_equal(input string name, input logic [127:0] actual,
			input logic [127:0] expected);
		if (actual !== expected) begin
			$display("[FAIL] time %0t %s: got 0x%0h, expected 0x%0h", $time, name,
				actual, expected);
			$display("** FAIL **");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	function automatic lc3b_word fill_word(input int idx);
		return 16'(idx * 40503) ^ 16'h5a3c;
	endfunction

	function automatic lc3b_word sign_extend5(input logic [4:0] imm);
		return {{11{imm[4]}}, imm};
	endfunction

	function automatic lc3b_word isa_result(input test_row row, input lc3b_word a,
			input lc3b_word b, input logic [4:0] imm);
		lc3b_word src2;
		src2 = row.imm ? sign_extend5(imm) : b;
		case (row.op)
			opc_add: return a + src2;
			opc_and: return a & src2;
			default: return ~a;
		endcase
	endfunction

	function automatic logic [2:0] isa_flags(input lc3b_word value);
		if (value[15])
			return 3'b100;
		if (value == 16'h0000)
			return 3'b010;
		return 3'b001;
	endfunction

	function automatic lc3b_word mem_instr(input logic [3:0] op, input logic [2:0] r,
			input logic [2:0] base, input logic [5:0] off6);
		return {op, r, base, off6};
	endfunction

	// R3 gets R1 combined with R2 or imm5
	function automatic lc3b_word alu_instr(input test_row row, input logic [4:0] imm);
		if (row.op == opc_not)
			return {opc_not, 3'd3, 3'd1, 6'b111111};
		if (row.imm)
			return {row.op, 3'd3, 3'd1, 1'b1, imm};
		return {row.op, 3'd3, 3'd1, 3'b000, 3'd2};
	endfunction

	function automatic lc3b_word branch_instr(input logic [2:0] nzp, input logic [8:0] off9);
		return {opc_br, nzp, off9};
	endfunction

	always_comb begin
		ifetch_rdata = '0;
		for (int k = 0; k < words_per_line; k++) begin
			if (int'(ifetch_address) * words_per_line + k < imem_words)
				ifetch_rdata[k*16 +: 16] = imem[int'(ifetch_address) * words_per_line + k];
		end
	end

	task automatic prepare_test(input int r);
		lc3b_word result;
		logic taken;
		int res_w;
		int marker_w;
		int final_w;
		result = isa_result(rows[r], op_a[r], op_b[r], op_imm[r]);
		taken = (rows[r].cond & isa_flags(result)) != 3'b000;
		res_w = 8 + int'(rows[r].offset);
		marker_w = 16 + (int'(rows[r].offset) + 3) % words_per_line;
		final_w = 24 + (int'(rows[r].offset) + 5) % words_per_line;
		for (int i = 0; i < imem_words; i++)
			imem[i] = 16'h0000;
		for (int i = 0; i < dmem_words; i++)
			dmem[i] = fill_word(i);
		dmem[0] = op_a[r];
		dmem[1] = op_b[r];
		// Each result is read three instructions after its producer
		imem[0] = mem_instr(opc_ldr, 3'd1, 3'd0, 6'd0);
		imem[1] = mem_instr(opc_ldr, 3'd2, 3'd0, 6'd1);
		imem[4] = alu_instr(rows[r], op_imm[r]);
		imem[7] = mem_instr(opc_str, 3'd3, 3'd0, 6'(res_w));
		// A taken BR jumps over the marker store at word 9
		imem[8] = branch_instr(rows[r].cond, 9'd1);
		imem[9] = mem_instr(opc_str, 3'd1, 3'd0, 6'(marker_w));
		imem[10] = mem_instr(opc_str, 3'd2, 3'd0, 6'(final_w));
		exp_word.delete();
		exp_data.delete();
		exp_word.push_back(res_w);
		exp_data.push_back(result);
		if (!taken) begin
			exp_word.push_back(marker_w);
			exp_data.push_back(op_a[r]);
		end
		exp_word.push_back(final_w);
		exp_data.push_back(op_b[r]);
		seen_addr.delete();
		seen_data.delete();
		seen_sel.delete();
	endtask

	task automatic apply_reset(input int r);
		@(posedge clk);
		#1;
		reset = 1'b1;
		prepare_test(r);
		repeat (2) begin
			@(posedge clk);
			#1;
			check_equal("mem_read", 128'(mem_read), 128'(0));
			check_equal("mem_write", 128'(mem_write), 128'(0));
		end
		reset = 1'b0;
	endtask

	task automatic run_test(input int r);
		int cycles;
		int lane;
		apply_reset(r);
		// First LDR needs three stages plus the IDLE to ACCESS step
		cycles = 0;
		do begin
			@(posedge clk);
			#1;
			cycles++;
			check_equal("mem_write", 128'(mem_write), 128'(0));
		end while (!mem_read);
		check_equal("cycles to first mem_read", 128'(cycles), 128'(4));
		while (seen_addr.size() < exp_word.size())
			@(posedge clk);
		repeat (drain_cycles)
			@(posedge clk);
		check_equal("store count", 128'(seen_addr.size()), 128'(exp_word.size()));
		foreach (exp_word[i]) begin
			lane = exp_word[i] % words_per_line;
			check_equal("mem_address", 128'(seen_addr[i]), 128'(exp_word[i] / words_per_line));
			check_equal("mem_sel", 128'(seen_sel[i]), 128'(16'h0003 << (2 * lane)));
			check_equal("mem_wdata", 128'(seen_data[i][lane*16 +: 16]), 128'(exp_data[i]));
		end
	endtask

	// Data memory, answers each access after 0 to 3 wait cycles
	initial begin : data_memory
		logic [31:0] bits;
		lc3b_wb_adr addr_held;
		lc3b_line data_held;
		logic write_held;
		int base;
		mem_resp = 1'b0;
		mem_rdata = '0;
		forever begin
			@(posedge clk);
			#1;
			mem_resp = 1'b0;
			if (!reset && (mem_read || mem_write)) begin
				addr_held = mem_address;
				data_held = mem_wdata;
				write_held = mem_write;
				bits = '0;
				if (random_delay)
					take_bits(2, bits);
				repeat (int'(bits[1:0])) begin
					@(posedge clk);
					#1;
					check_equal("mem_address", 128'(mem_address), 128'(addr_held));
					check_equal("mem_wdata", mem_wdata, data_held);
					check_equal("mem_write", 128'(mem_write), 128'(write_held));
					check_equal("mem_read", 128'(mem_read), 128'(!write_held));
				end
				base = int'(mem_address) * words_per_line;
				if (mem_write) begin
					seen_addr.push_back(mem_address);
					seen_data.push_back(mem_wdata);
					seen_sel.push_back(mem_sel);
					for (int k = 0; k < words_per_line; k++) begin
						if (mem_sel[2*k] && base + k < dmem_words)
							dmem[base + k] = mem_wdata[k*16 +: 16];
					end
				end else begin
					for (int k = 0; k < words_per_line; k++) begin
						mem_rdata[k*16 +: 16] = (base + k < dmem_words) ?
							dmem[base + k] : fill_word(base + k);
					end
				end
				mem_resp = 1'b1;
			end
		end
	end

	initial begin : watchdog
		#(num_rows * num_passes * 200 * clk_period);
		$display("Timeout: the tests did not complete in the allowed time");
		$display("** FAIL **");
		$fatal(1, "Watchdog expired");
	end

	initial begin : main
		logic [31:0] bits;
		reset = 1'b1;
		for (int r = 0; r < num_rows; r++) begin
			take_bits(16, bits);
			op_a[r] = bits[15:0];
			take_bits(16, bits);
			op_b[r] = bits[15:0];
			take_bits(5, bits);
			op_imm[r] = bits[4:0];
		end
		// Same operands twice, first with immediate answers then with wait states
		for (int pass = 0; pass < num_passes; pass++) begin
			random_delay = (pass == 1);
			for (int r = 0; r < num_rows; r++)
				run_test(r);
		end
		$display("** PASS **");
		$finish;
	end

endmodule : cpu_tb

`default_nettype wire

// File: build.f
+incdir+source
source/lc3b_types.sv
source/lc3b_ctrl_types.sv
source/control_rom.sv
source/regfile.sv
source/alu.sv
source/mem_stall_fsm.sv
source/branch_shadow_timer.sv
source/datapath.sv
source/cpu.sv
verification/cpu_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS := --binary --timing --assert -Wno-fatal
TOP := cpu_tb
FILELIST := build.f
OBJ_DIR := obj_dir

SIM := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard source/*.sv source/*.svh verification/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: compile
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
